// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  localparam int word_w     = 32;
  localparam int way_n      = 4;
  localparam int set_w      = 4;
  localparam int offset_w   = 4;
  localparam int tag_w      = 22;  // Address bits 31 to 10
  localparam int line_words = 16;
  localparam int byte_sel_w = 2;   // Byte within a word

  typedef logic [word_w-1:0]        word_t;
  typedef logic [tag_w-1:0]         tag_t;
  typedef logic [set_w-1:0]         set_t;
  typedef logic [offset_w-1:0]      offset_t;
  typedef logic [$clog2(way_n)-1:0] way_t;
  typedef logic [1:0]               age_t;

  typedef struct packed {
    logic [31:0]         addr;
    word_t               wdata;
    logic [word_w/8-1:0] wbyte;  // Bit 3 is the top byte
    logic                write;
  } cpu_req_t;

  typedef struct packed {
    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic victim_dirty;
    tag_t victim_tag;
  } lookup_t;

  typedef struct packed {
    logic touch;      // Access done, update ages
    logic set_dirty;
    logic fill;       // Valid and clean with the request tag
    way_t way;
  } tag_cmd_t;

  typedef struct packed {
    logic                we;
    way_t                way;
    offset_t             offset;
    logic [word_w/8-1:0] wbyte;
    word_t               wdata;
  } word_cmd_t;

endpackage

`default_nettype wire

// File: verilog/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire dcache_pkg::set_t     set,
  input  wire dcache_pkg::tag_t     tag,
  input  wire dcache_pkg::tag_cmd_t cmd,
  output dcache_pkg::lookup_t       lookup
);

  localparam int set_n = 2 ** dcache_pkg::set_w;

  logic [dcache_pkg::way_n-1:0] valid_q [set_n];
  logic [dcache_pkg::way_n-1:0] dirty_q [set_n];
  dcache_pkg::tag_t             tag_q   [set_n][dcache_pkg::way_n];
  dcache_pkg::age_t             age_q   [set_n][dcache_pkg::way_n];

  logic [dcache_pkg::way_n-1:0] hit_vec;
  dcache_pkg::way_t             victim;

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    lookup = '0;
    for (int w = 0; w < dcache_pkg::way_n; w++)
    begin
      hit_vec[w] = valid_q[set][w] && (tag_q[set][w] == tag);
      if (hit_vec[w])
        lookup.hit_way = dcache_pkg::way_t'(w);
    end
    lookup.hit = |hit_vec;

    // Lowest index among the oldest ways
    victim = '0;
    for (int w = 1; w < dcache_pkg::way_n; w++)
    begin
      if (age_q[set][w] > age_q[set][victim])
        victim = dcache_pkg::way_t'(w);
    end
    // First invalid way takes priority
    for (int w = dcache_pkg::way_n - 1; w >= 0; w--)
    begin
      if (!valid_q[set][w])
        victim = dcache_pkg::way_t'(w);
    end

    lookup.victim_way   = victim;
    lookup.victim_dirty = valid_q[set][victim] && dirty_q[set][victim];
    lookup.victim_tag   = tag_q[set][victim];
  end

  //////////////////////////////////////////////////////////////////////
  // State update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < set_n; s++)
      begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        for (int w = 0; w < dcache_pkg::way_n; w++)
        begin
          age_q[s][w] <= '0;
        end
      end
    end
    else
    begin
      if (cmd.fill)
      begin
        valid_q[set][cmd.way] <= 1'b1;
        dirty_q[set][cmd.way] <= 1'b0;
      end
      if (cmd.set_dirty)
        dirty_q[set][cmd.way] <= 1'b1;
      if (cmd.touch)
      begin
        for (int w = 0; w < dcache_pkg::way_n; w++)
        begin
          if (dcache_pkg::way_t'(w) == cmd.way)
            age_q[set][w] <= '0;
          else if (age_q[set][w] <= age_q[set][cmd.way])
            age_q[set][w] <= age_q[set][w] + 1'b1;  // Wraps past 3
        end
      end
    end
  end

  // Tag array
  always_ff @(posedge clk)
  begin
    if (cmd.fill)
      tag_q[set][cmd.way] <= tag;
  end

  // A tag lives in one way at most
  assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec))
    else $error("tag_store: more than one way hits");

endmodule

`default_nettype wire

// File: verilog/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store
(
  input  wire                        clk,
  input  wire dcache_pkg::set_t      set,
  input  wire dcache_pkg::word_cmd_t cmd,
  input  wire dcache_pkg::offset_t   req_offset,
  input  wire dcache_pkg::way_t      hit_way,
  input  wire dcache_pkg::way_t      wb_way,
  input  wire dcache_pkg::offset_t   wb_offset,
  output dcache_pkg::word_t          cpu_word,
  output dcache_pkg::word_t          wb_word
);

  localparam int set_n = 2 ** dcache_pkg::set_w;

  dcache_pkg::word_t mem_q [dcache_pkg::way_n][set_n][dcache_pkg::line_words];

  // Byte merge on write
  always_ff @(posedge clk)
  begin
    if (cmd.we)
    begin
      for (int b = 0; b < dcache_pkg::word_w / 8; b++)
      begin
        if (cmd.wbyte[b])
          mem_q[cmd.way][set][cmd.offset][8*b +: 8] <= cmd.wdata[8*b +: 8];
      end
    end
  end

  assign cpu_word = mem_q[hit_way][set][req_offset];
  assign wb_word  = mem_q[wb_way][set][wb_offset];   // Victim line for write-back

  // CPU writes carry the request byte enables, refill writes all four
  assert property (@(posedge clk) cmd.we |-> (cmd.wbyte != '0))
    else $error("line_store: write with no byte enabled");

endmodule

`default_nettype wire

// File: verilog/miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module miss_ctrl
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        req,
  input  wire dcache_pkg::cpu_req_t  req_info,
  input  wire dcache_pkg::lookup_t   lookup,
  input  wire dcache_pkg::word_t     cpu_word,
  input  wire dcache_pkg::word_t     wb_word,
  input  wire dcache_pkg::word_t     sdata,
  input  wire                        rdata_ok,
  input  wire                        wdata_ok,
  output dcache_pkg::tag_cmd_t       tag_cmd,
  output dcache_pkg::word_cmd_t      word_cmd,
  output dcache_pkg::offset_t        wb_offset,
  output dcache_pkg::word_t          rdata,
  output logic                       ok,
  output logic                       miss,
  output logic                       sen,
  output logic [31:0]                raddr,
  output logic                       wen,
  output logic [31:0]                waddr,
  output dcache_pkg::word_t          wdata
);

  localparam int line_lsb = dcache_pkg::offset_w + dcache_pkg::byte_sel_w;

  typedef enum logic [1:0] {st_idle, st_wb, st_refill, st_done} state_t;

  state_t              state_q;
  state_t              state_d;
  dcache_pkg::offset_t count_q;
  dcache_pkg::way_t    victim_way_q;
  dcache_pkg::tag_t    victim_tag_q;
  dcache_pkg::set_t    req_set;
  dcache_pkg::offset_t req_offset;
  logic                lookup_en;
  logic                hit_now;
  logic                miss_now;
  logic                last_word;

  assign req_set    = req_info.addr[line_lsb +: dcache_pkg::set_w];
  assign req_offset = req_info.addr[dcache_pkg::byte_sel_w +: dcache_pkg::offset_w];

  // New request, or the retry once the line is in
  assign lookup_en = (state_q == st_idle && req && !ok) || state_q == st_done;
  assign hit_now   = lookup_en && lookup.hit;
  assign miss_now  = state_q == st_idle && req && !ok && !lookup.hit;
  assign last_word = count_q == dcache_pkg::offset_t'(dcache_pkg::line_words - 1);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
        if (miss_now)
          state_d = lookup.victim_dirty ? st_wb : st_refill;
      st_wb:
        if (wdata_ok && last_word)
          state_d = st_refill;
      st_refill:
        if (rdata_ok && last_word)
          state_d = st_done;
      default:
        state_d = st_idle;
    endcase
  end

  // Commands to the stores
  always_comb
  begin
    tag_cmd         = '0;
    word_cmd        = '0;
    tag_cmd.way     = lookup.hit_way;
    word_cmd.way    = lookup.hit_way;
    word_cmd.offset = req_offset;
    word_cmd.wbyte  = req_info.wbyte;
    word_cmd.wdata  = req_info.wdata;
    if (hit_now)
    begin
      tag_cmd.touch     = 1'b1;
      tag_cmd.set_dirty = req_info.write;
      word_cmd.we       = req_info.write;
    end
    else if (state_q == st_refill)
    begin
      word_cmd.way    = victim_way_q;
      word_cmd.offset = count_q;
      word_cmd.wbyte  = '1;
      word_cmd.wdata  = sdata;
      word_cmd.we     = rdata_ok;
      tag_cmd.way     = victim_way_q;
      tag_cmd.fill    = rdata_ok && last_word;   // Tag goes in with word 15
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q <= st_idle;
      count_q <= '0;
      ok      <= 1'b0;
      miss    <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      ok      <= hit_now;
      if (miss_now)
        miss <= 1'b1;
      else if (hit_now)
        miss <= 1'b0;
      // Burst word count, back to 0 after word 15
      if ((state_q == st_wb && wdata_ok) || (state_q == st_refill && rdata_ok))
        count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (hit_now)
      rdata <= req_info.write ? req_info.wdata : cpu_word;
    if (miss_now)
    begin
      victim_way_q <= lookup.victim_way;
      victim_tag_q <= lookup.victim_tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory side
  //////////////////////////////////////////////////////////////////////

  assign wen       = state_q == st_wb;
  assign sen       = state_q == st_refill;
  assign wb_offset = count_q;
  assign wdata     = wb_word;
  assign raddr     = {req_info.addr[31:line_lsb], {line_lsb{1'b0}}};
  assign waddr     = {victim_tag_q, req_set, {line_lsb{1'b0}}};

  // CPU sees a single pulse per request
  assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else $error("miss_ctrl: ok held for two cycles");

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       req,
  input  wire dcache_pkg::cpu_req_t req_info,
  output wire dcache_pkg::word_t    rdata,
  output wire                       ok,
  output wire                       miss,
  output wire                       sen,
  output wire [31:0]                raddr,
  input  wire dcache_pkg::word_t    sdata,
  input  wire                       rdata_ok,
  output wire                       wen,
  output wire [31:0]                waddr,
  output wire dcache_pkg::word_t    wdata,
  input  wire                       wdata_ok
);

  localparam int offset_lsb = dcache_pkg::byte_sel_w;
  localparam int set_lsb    = offset_lsb + dcache_pkg::offset_w;
  localparam int tag_lsb    = set_lsb + dcache_pkg::set_w;

  wire dcache_pkg::tag_t      req_tag;
  wire dcache_pkg::set_t      req_set;
  wire dcache_pkg::offset_t   req_offset;
  wire dcache_pkg::lookup_t   lookup;
  wire dcache_pkg::tag_cmd_t  tag_cmd;
  wire dcache_pkg::word_cmd_t word_cmd;
  wire dcache_pkg::offset_t   wb_offset;
  wire dcache_pkg::word_t     cpu_word;
  wire dcache_pkg::word_t     wb_word;

  // Address split
  assign req_tag    = req_info.addr[tag_lsb +: dcache_pkg::tag_w];
  assign req_set    = req_info.addr[set_lsb +: dcache_pkg::set_w];
  assign req_offset = req_info.addr[offset_lsb +: dcache_pkg::offset_w];

  tag_store u_tag_store
  (
    .clk    (clk),
    .rst    (rst),
    .set    (req_set),
    .tag    (req_tag),
    .cmd    (tag_cmd),
    .lookup (lookup)
  );

  line_store u_line_store
  (
    .clk        (clk),
    .set        (req_set),
    .cmd        (word_cmd),
    .req_offset (req_offset),
    .hit_way    (lookup.hit_way),
    .wb_way     (lookup.victim_way),   // Stable until the fill
    .wb_offset  (wb_offset),
    .cpu_word   (cpu_word),
    .wb_word    (wb_word)
  );

  miss_ctrl u_miss_ctrl
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_info  (req_info),
    .lookup    (lookup),
    .cpu_word  (cpu_word),
    .wb_word   (wb_word),
    .sdata     (sdata),
    .rdata_ok  (rdata_ok),
    .wdata_ok  (wdata_ok),
    .tag_cmd   (tag_cmd),
    .word_cmd  (word_cmd),
    .wb_offset (wb_offset),
    .rdata     (rdata),
    .ok        (ok),
    .miss      (miss),
    .sen       (sen),
    .raddr     (raddr),
    .wen       (wen),
    .waddr     (waddr),
    .wdata     (wdata)
  );

endmodule

`default_nettype wire

// File: include/dcache_tests.svh
//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

// Cold miss in set 9
task automatic read_empty_set();
  cpu_access(32'h0000_1248, 1'b0, '0, 4'b0000);
endtask

task automatic read_hit_same_line();
  cpu_access(32'h0000_1274, 1'b0, '0, 4'b0000);  // Same line as above
endtask

// Bytes 0 and 2 only
task automatic write_hit_merge();
  cpu_access(32'h0000_1250, 1'b1, 32'ha1b2_c3d4, 4'b0101);
  cpu_access(32'h0000_1250, 1'b0, '0, 4'b0000);
endtask

// Refill of set 14, then the merge
task automatic write_miss_refill();
  cpu_access(32'h0000_2384, 1'b1, 32'h1357_9bdf, 4'b1100);
  cpu_access(32'h0000_2384, 1'b0, '0, 4'b0000);
endtask

// Five lines in set 3, all dirtied
task automatic evict_dirty_victim();
  logic [31:0] line_addr;
  for (int k = 0; k < 5; k++)
  begin
    line_addr = 32'h0000_4000 + (k << 10) + 32'h0000_00c0;
    cpu_access(line_addr, 1'b1, 32'hc0de_0000 + k, 4'b1111);
    cpu_access(line_addr + 32'h14, 1'b1, 32'h00ee_ff00 + (k << 8), 4'b0110);
    // Line 0 becomes youngest before the fifth fill
    if (k == 3)
      cpu_access(32'h0000_40c0, 1'b0, '0, 4'b0000);
  end
  // Line 1 comes back from memory
  cpu_access(32'h0000_44c0, 1'b0, '0, 4'b0000);
  cpu_access(32'h0000_44d4, 1'b0, '0, 4'b0000);
endtask

task automatic random_ack_gaps();
  max_gap = 3;
  reset_all();
  write_miss_refill();
  evict_dirty_victim();
  max_gap = 0;
endtask

// File: verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int          clk_period   = 100;
  localparam int          rst_cycles   = 10;
  localparam int          req_total    = 34;    // Requests over all tests
  localparam int          mem_words    = 16384; // 64 KB of memory
  localparam int          set_n        = 16;
  localparam logic [31:0] fill_pattern = 32'h5a3c_96e1;

  logic                 clk      = 1'b0;
  logic                 rst      = 1'b1;
  logic                 req      = 1'b0;
  dcache_pkg::cpu_req_t req_info = '0;
  dcache_pkg::word_t    sdata    = '0;
  logic                 rdata_ok = 1'b0;
  logic                 wdata_ok = 1'b0;
  dcache_pkg::word_t    rdata;
  logic                 ok;
  logic                 miss;
  logic                 sen;
  logic [31:0]          raddr;
  logic                 wen;
  logic [31:0]          waddr;
  dcache_pkg::word_t    wdata;

  integer seed    = 32'h0e94_0f0b;
  int     max_gap = 0;
  int     checks  = 0;
  int     errors  = 0;

  // Memory model state
  dcache_pkg::word_t mem      [mem_words];
  dcache_pkg::word_t wb_words [16];
  logic [31:0]       last_raddr = '0;
  logic [31:0]       last_waddr = '0;
  int                sen_bursts = 0;
  int                wen_bursts = 0;
  int                rd_cnt     = 0;
  int                wr_cnt     = 0;
  int                rd_gap     = 0;
  int                wr_gap     = 0;
  logic              sen_prev   = 1'b0;
  logic              wen_prev   = 1'b0;

  // Reference model state
  logic [3:0]        ref_valid [set_n];
  logic [3:0]        ref_dirty [set_n];
  dcache_pkg::tag_t  ref_tag   [set_n][4];
  logic [1:0]        ref_age   [set_n][4];
  dcache_pkg::word_t ref_data  [set_n][4][16];
  dcache_pkg::word_t ref_mem   [mem_words];
  dcache_pkg::word_t exp_line  [16];
  logic              exp_miss;
  logic              exp_wb;
  int                exp_way;
  logic [31:0]       exp_raddr;
  logic [31:0]       exp_waddr;
  dcache_pkg::word_t exp_rdata;

  dcache_top u_dcache_top
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_info (req_info),
    .rdata    (rdata),
    .ok       (ok),
    .miss     (miss),
    .sen      (sen),
    .raddr    (raddr),
    .sdata    (sdata),
    .rdata_ok (rdata_ok),
    .wen      (wen),
    .waddr    (waddr),
    .wdata    (wdata),
    .wdata_ok (wdata_ok)
  );

  initial
  begin
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic int ack_gap();
    if (max_gap == 0)
      return 0;
    return $unsigned($random(seed)) % (max_gap + 1);
  endfunction

  function automatic int mem_index(input logic [31:0] addr, input int idx);
    return int'(((addr >> 2) + idx) % mem_words);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    rdata_ok = 1'b0;
    wdata_ok = 1'b0;
    if (wen)
    begin
      if (!wen_prev)
      begin
        wen_bursts++;
        last_waddr = waddr;
        wr_cnt     = 0;
        wr_gap     = ack_gap();
      end
      if (wr_gap > 0)
        wr_gap--;
      else
      begin
        wdata_ok         = 1'b1;  // Takes the word shown now
        wb_words[wr_cnt] = wdata;
        mem[mem_index(waddr, wr_cnt)] = wdata;
        wr_cnt++;
        wr_gap = ack_gap();
      end
    end
    if (sen)
    begin
      if (!sen_prev)
      begin
        sen_bursts++;
        last_raddr = raddr;
        rd_cnt     = 0;
        rd_gap     = ack_gap();
      end
      if (rd_gap > 0)
        rd_gap--;
      else
      begin
        rdata_ok = 1'b1;
        sdata    = mem[mem_index(raddr, rd_cnt)];
        rd_cnt++;
        rd_gap = ack_gap();
      end
    end
    sen_prev = sen;
    wen_prev = wen;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // First invalid way, else the oldest with the lowest index
  function automatic int pick_victim(input int s);
    int v;
    v = -1;
    for (int w = 0; w < 4; w++)
    begin
      if (v < 0 && !ref_valid[s][w])
        v = w;
    end
    if (v < 0)
    begin
      v = 0;
      for (int w = 1; w < 4; w++)
      begin
        if (ref_age[s][w] > ref_age[s][v])
          v = w;
      end
    end
    return v;
  endfunction

  task automatic predict(input logic [31:0] addr, input logic write,
                         input dcache_pkg::word_t wdata_in, input logic [3:0] wbyte);
    int               s;
    int               off;
    int               way;
    int               base;
    logic [1:0]       old_age;
    dcache_pkg::tag_t tg;
    s         = addr[9:6];
    off       = addr[5:2];
    tg        = addr[31:10];
    way       = 0;
    exp_miss  = 1'b1;
    exp_wb    = 1'b0;
    exp_raddr = {addr[31:6], 6'b000000};
    for (int w = 0; w < 4; w++)
    begin
      if (ref_valid[s][w] && ref_tag[s][w] == tg)
      begin
        way      = w;
        exp_miss = 1'b0;
      end
    end
    if (exp_miss)
    begin
      way     = pick_victim(s);
      exp_way = way;
      if (ref_valid[s][way] && ref_dirty[s][way])
      begin
        exp_wb    = 1'b1;
        exp_waddr = {ref_tag[s][way], addr[9:6], 6'b000000};
        base      = mem_index(exp_waddr, 0);
        for (int i = 0; i < 16; i++)
        begin
          exp_line[i]       = ref_data[s][way][i];
          ref_mem[base + i] = ref_data[s][way][i];
        end
      end
      base = mem_index(exp_raddr, 0);
      for (int i = 0; i < 16; i++)
        ref_data[s][way][i] = ref_mem[base + i];
      ref_valid[s][way] = 1'b1;
      ref_dirty[s][way] = 1'b0;
      ref_tag[s][way]   = tg;
    end
    // Age update on the completing hit
    old_age = ref_age[s][way];
    for (int w = 0; w < 4; w++)
    begin
      if (w != way && ref_age[s][w] <= old_age)
        ref_age[s][w] = ref_age[s][w] + 2'd1;
    end
    ref_age[s][way] = 2'd0;
    if (write)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (wbyte[b])
          ref_data[s][way][off][8*b +: 8] = wdata_in[8*b +: 8];
      end
      ref_dirty[s][way] = 1'b1;
    end
    exp_rdata = ref_data[s][way][off];
  endtask

  task automatic check(input string name, input logic [31:0] got,
                       input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  task automatic reset_all();
    @(negedge clk);
    rst = 1'b1;
    for (int s = 0; s < set_n; s++)
    begin
      ref_valid[s] = '0;
      ref_dirty[s] = '0;
      for (int w = 0; w < 4; w++)
      begin
        ref_tag[s][w] = '0;
        ref_age[s][w] = '0;
      end
    end
    for (int i = 0; i < mem_words; i++)
    begin
      mem[i]     = i ^ fill_pattern;
      ref_mem[i] = i ^ fill_pattern;
    end
    repeat (rst_cycles) @(negedge clk);
    rst = 1'b0;
  endtask

  // One CPU request, checked against the reference model
  task automatic cpu_access(input logic [31:0] addr, input logic write,
                            input dcache_pkg::word_t wdata_in, input logic [3:0] wbyte);
    int   cycles;
    int   sen_before;
    int   wen_before;
    logic first_miss;
    predict(addr, write, wdata_in, wbyte);
    sen_before = sen_bursts;
    wen_before = wen_bursts;
    cycles     = 0;
    first_miss = 1'b0;
    @(negedge clk);
    req            = 1'b1;
    req_info.addr  = addr;
    req_info.write = write;
    req_info.wdata = wdata_in;
    req_info.wbyte = wbyte;
    do
    begin
      @(negedge clk);
      cycles++;
      if (cycles == 1)
        first_miss = miss;
    end
    while (!ok);
    req = 1'b0;
    check("miss", first_miss, exp_miss);
    check("miss at ok", miss, 1'b0);
    if (!write)
      check("rdata", rdata, exp_rdata);
    if (!exp_miss)
      check("hit latency", cycles, 1);
    check("sen bursts", sen_bursts - sen_before, exp_miss);
    check("wen bursts", wen_bursts - wen_before, exp_wb);
    if (exp_miss)
    begin
      check("raddr", last_raddr, exp_raddr);
      check("victim way", u_dcache_top.u_miss_ctrl.victim_way_q, exp_way);
    end
    if (exp_wb)
    begin
      check("waddr", last_waddr, exp_waddr);
      for (int i = 0; i < 16; i++)
        check($sformatf("wdata[%0d]", i), wb_words[i], exp_line[i]);
    end
  endtask

  `include "dcache_tests.svh"

  initial
  begin
    reset_all();
    read_empty_set();
    read_hit_same_line();
    write_hit_merge();
    write_miss_refill();
    evict_dirty_victim();
    random_ack_gaps();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(clk_period * (req_total * 200 + 2 * rst_cycles));
    $display("Timeout: the DUT stopped completing requests");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
verilog/dcache_pkg.sv
verilog/tag_store.sv
verilog/line_store.sv
verilog/miss_ctrl.sv
verilog/dcache_top.sv
verif/dcache_tb.sv
